// ==== design/trace_pkg.sv ====
// types and widths for the traced instruction stream and the packet it becomes
// imported by the capture, packet and fifo blocks
`default_nettype none

package trace_pkg;

    // core side widths
    localparam int xlen = 32;
    localparam int instr_w = 32;

    // packet field widths
    localparam int stamp_w = 16;
    localparam int evt_count_w = 8;
    localparam int num_events = 4;
    localparam int packet_w = instr_w + stamp_w + xlen + num_events * evt_count_w;

    typedef logic [instr_w-1:0] instr_t;
    typedef logic [xlen-1:0] pc_t;
    // wraps, only the delta matters
    typedef logic [stamp_w-1:0] stamp_t;
    typedef logic [evt_count_w-1:0] evt_count_t;
    typedef logic [num_events-1:0] evt_vec_t;
    // msb first: instr, stamp delta, pc, count 0 .. count 3
    typedef logic [packet_w-1:0] packet_t;

    // wfi encoding
    localparam instr_t wfi_instr = 32'h1050_0073;

    // packet fifo sizing, depth kept a power of two
    localparam int fifo_depth = 8;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    typedef logic [fifo_ptr_w-1:0] fifo_ptr_t;
    typedef logic [fifo_ptr_w:0] fifo_cnt_t;
    localparam fifo_cnt_t fifo_full = fifo_cnt_t'(fifo_depth);

endpackage

`default_nettype wire

// ==== design/monitor_ctrl_pkg.sv ====
// control side definitions: register map, write data and trigger window state
// used by the register block, the capture gate and the top level
`default_nettype none

package monitor_ctrl_pkg;

    localparam int ctrl_addr_w = 4;
    localparam int ctrl_data_w = 32;

    // register map, unlisted addresses are ignored on write
    typedef enum logic [ctrl_addr_w-1:0] {
        start_en    = 4'd0,
        end_en      = 4'd1,
        start_addr  = 4'd2,
        end_addr    = 4'd3,
        lower_en    = 4'd4,
        upper_en    = 4'd5,
        lower_bound = 4'd6,
        upper_bound = 4'd7
    } ctrl_addr_t;

    typedef logic [ctrl_data_w-1:0] ctrl_data_t;

    // trigger window, leaves idle on a start pc match
    typedef enum logic [1:0] {
        win_idle,
        win_started,
        win_ended
    } window_t;

endpackage

`default_nettype wire

// ==== design/trace_cfg_if.sv ====
// decoded configuration from the register block to the capture gate
// the register block drives everything through the source modport
`timescale 1ns/1ps
`default_nettype none

interface trace_cfg_if import trace_pkg::*; ();

    // trigger addresses with their enables
    logic start_en;
    pc_t  start_addr;
    logic end_en;
    pc_t  end_addr;

    // monitored address range, bounds inclusive
    logic lower_en;
    pc_t  lower_bound;
    logic upper_en;
    pc_t  upper_bound;

    // high in the cycle of an accepted write
    logic cfg_write;

    modport source (
        output start_en, start_addr, end_en, end_addr,
        output lower_en, lower_bound, upper_en, upper_bound,
        output cfg_write
    );

    modport sink (
        input start_en, start_addr, end_en, end_addr,
        input lower_en, lower_bound, upper_en, upper_bound,
        input cfg_write
    );

endinterface

`default_nettype wire

// ==== design/monitor_regs.sv ====
// configuration registers written through a strobed address/data port
// a write lands on the rising edge of ctrl_write_enable only, so a slow
// software-driven strobe held high for many cycles writes once
`timescale 1ns/1ps
`default_nettype none

module monitor_regs import monitor_ctrl_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire ctrl_addr_t ctrl_addr,
    input  wire ctrl_data_t ctrl_wdata,
    input  wire logic       ctrl_write_enable,
    trace_cfg_if.source     cfg
);

    // strobe value seen at the previous edge
    logic we_q;
    logic write_acc;

    // rising edge of the strobe
    assign write_acc = ctrl_write_enable & ~we_q;

    // window logic must skip trigger matches in this cycle
    assign cfg.cfg_write = write_acc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else begin
            we_q <= ctrl_write_enable;
        end
    end

    // register file
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.start_en    <= 1'b0;
            cfg.end_en      <= 1'b0;
            cfg.start_addr  <= '0;
            cfg.end_addr    <= '1;
            cfg.lower_en    <= 1'b0;
            cfg.upper_en    <= 1'b0;
            // open range until software narrows it
            cfg.lower_bound <= '0;
            cfg.upper_bound <= '1;
        end else if (write_acc) begin
            case (ctrl_addr)
                // enables only look at bit 0
                start_en:    cfg.start_en    <= ctrl_wdata[0];
                end_en:      cfg.end_en      <= ctrl_wdata[0];
                start_addr:  cfg.start_addr  <= ctrl_wdata;
                end_addr:    cfg.end_addr    <= ctrl_wdata;
                lower_en:    cfg.lower_en    <= ctrl_wdata[0];
                upper_en:    cfg.upper_en    <= ctrl_wdata[0];
                lower_bound: cfg.lower_bound <= ctrl_wdata;
                upper_bound: cfg.upper_bound <= ctrl_wdata;
                default: begin
                    // unmapped address, write dropped
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/capture_gate.sv ====
// decides per cycle whether the current instruction is traced
// combines trigger window, address range and the wfi stop count
`timescale 1ns/1ps
`default_nettype none

module capture_gate import trace_pkg::*, monitor_ctrl_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire instr_t instr,
    input  wire pc_t    pc,
    input  wire logic   pc_valid,
    input  wire logic   en,
    trace_cfg_if.sink   cfg,
    output logic        capture,
    output logic        is_wfi
);

    window_t    win_q;
    logic [1:0] wfi_cnt_q;
    logic       start_hit;
    logic       end_hit;
    logic       win_ok;
    logic       range_ok;

    assign is_wfi = (instr == wfi_instr);

    // trigger matches, no pc_valid needed
    assign start_hit = cfg.start_en && (pc == cfg.start_addr);
    assign end_hit   = cfg.end_en && (pc == cfg.end_addr);

    // window state, matches ignored during a register write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_q <= win_idle;
        end else if (!cfg.cfg_write) begin
            // end wins when both addresses match
            if (end_hit) begin
                win_q <= win_ended;
            end else if (start_hit) begin
                win_q <= win_started;
            end
        end
    end

    // consecutive wfi cycles, saturates at 2
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wfi_cnt_q <= 2'd0;
        end else if (is_wfi && en && (wfi_cnt_q < 2'd2)) begin
            wfi_cnt_q <= wfi_cnt_q + 2'd1;
        end else if (!is_wfi) begin
            wfi_cnt_q <= 2'd0;
        end
    end

    // disabled triggers never block capture
    assign win_ok = (!cfg.start_en || (win_q == win_started))
                  && (!cfg.end_en || (win_q != win_ended));

    // bounds inclusive
    assign range_ok = (!cfg.lower_en || (pc >= cfg.lower_bound))
                    && (!cfg.upper_en || (pc <= cfg.upper_bound));

    // same-cycle decision on the state from before this edge
    assign capture = en && pc_valid && (wfi_cnt_q < 2'd2) && win_ok && range_ok;

endmodule

`default_nettype wire

// ==== design/packet_builder.sv ====
// builds the trace packet for the current cycle
// timestamp delta and event counts cover the time since the last capture
`timescale 1ns/1ps
`default_nettype none

module packet_builder import trace_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire instr_t   instr,
    input  wire pc_t      pc,
    input  wire evt_vec_t events,
    input  wire logic     capture,
    output packet_t       packet
);

    // free running, wraps at 16 bits
    stamp_t cycle_q;
    // cycle count at the last capture
    stamp_t last_q;
    stamp_t delta;
    evt_count_t cnt_q [num_events];
    logic [num_events*evt_count_w-1:0] counts_flat;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_q <= '0;
            last_q  <= '0;
        end else begin
            cycle_q <= cycle_q + stamp_t'(1);
            if (capture) begin
                last_q <= cycle_q;
            end
        end
    end

    // modular subtract handles counter wrap
    assign delta = cycle_q - last_q;

    // per event saturating counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_events; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_events; i++) begin
                // capture cycle itself is not counted
                if (capture) begin
                    cnt_q[i] <= '0;
                end else if (events[i] && (cnt_q[i] != '1)) begin
                    cnt_q[i] <= cnt_q[i] + evt_count_t'(1);
                end
            end
        end
    end

    // count 0 sits in the highest count slot
    always_comb begin
        counts_flat = '0;
        for (int i = 0; i < num_events; i++) begin
            counts_flat[(num_events-1-i)*evt_count_w +: evt_count_w] = cnt_q[i];
        end
    end

    assign packet = {instr, delta, pc, counts_flat};

endmodule

`default_nettype wire

// ==== design/trace_stream_fifo.sv ====
// small packet fifo in front of the axi-stream master port
// tlast is decided on push and stored alongside each packet
`timescale 1ns/1ps
`default_nettype none

module trace_stream_fifo import trace_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        push,
    input  wire packet_t     packet,
    input  wire logic        is_wfi,
    input  wire logic [31:0] tlast_interval,
    output logic             M_AXIS_tvalid,
    input  wire logic        M_AXIS_tready,
    output packet_t          M_AXIS_tdata,
    output logic             M_AXIS_tlast
);

    // storage, no reset
    packet_t data_mem [fifo_depth];
    logic    last_mem [fifo_depth];

    fifo_ptr_t   wr_ptr_q;
    fifo_ptr_t   rd_ptr_q;
    fifo_cnt_t   count_q;
    // accepted pushes since the last tlast
    logic [31:0] push_cnt_q;

    logic push_ok;
    logic pop;
    logic interval_hit;
    logic tlast_in;

    // full fifo drops the capture, even with a pop pending
    assign push_ok = push && (count_q != fifo_full);
    assign pop     = M_AXIS_tvalid && M_AXIS_tready;

    // interval 0 disables the counted tlast
    assign interval_hit = (tlast_interval != 32'd0)
                        && ((push_cnt_q + 32'd1) == tlast_interval);
    assign tlast_in     = is_wfi || interval_hit;

    always_ff @(posedge clk) begin
        if (push_ok) begin
            data_mem[wr_ptr_q] <= packet;
            last_mem[wr_ptr_q] <= tlast_in;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            push_cnt_q <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q   <= wr_ptr_q + fifo_ptr_t'(1);
                push_cnt_q <= tlast_in ? 32'd0 : push_cnt_q + 32'd1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + fifo_ptr_t'(1);
            end
            case ({push_ok, pop})
                2'b10:   count_q <= count_q + fifo_cnt_t'(1);
                2'b01:   count_q <= count_q - fifo_cnt_t'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    // head of the fifo on the stream port
    assign M_AXIS_tvalid = (count_q != '0);
    assign M_AXIS_tdata  = data_mem[rd_ptr_q];
    // stale flag masked while empty
    assign M_AXIS_tlast  = M_AXIS_tvalid && last_mem[rd_ptr_q];

endmodule

`default_nettype wire

// ==== design/trace_monitor_top.sv ====
// trace monitor for a risc-v core, captured instructions leave as axi-stream packets
// software sets triggers and address range through the strobed register port
`timescale 1ns/1ps
`default_nettype none

module trace_monitor_top import trace_pkg::*, monitor_ctrl_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,

    // core trace inputs
    input  wire instr_t      instr,
    input  wire pc_t         pc,
    input  wire logic        pc_valid,
    input  wire logic        en,
    input  wire evt_vec_t    events,

    // register write port
    input  wire ctrl_addr_t  ctrl_addr,
    input  wire ctrl_data_t  ctrl_wdata,
    input  wire logic        ctrl_write_enable,

    // stream output
    input  wire logic [31:0] tlast_interval,
    output logic             M_AXIS_tvalid,
    input  wire logic        M_AXIS_tready,
    output packet_t          M_AXIS_tdata,
    output logic             M_AXIS_tlast
);

    trace_cfg_if cfg_bus ();

    logic    capture;
    logic    is_wfi;
    packet_t packet;

    monitor_regs u_regs (
        .clk               (clk),
        .rst_n             (rst_n),
        .ctrl_addr         (ctrl_addr),
        .ctrl_wdata        (ctrl_wdata),
        .ctrl_write_enable (ctrl_write_enable),
        .cfg               (cfg_bus.source)
    );

    capture_gate u_gate (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .pc       (pc),
        .pc_valid (pc_valid),
        .en       (en),
        .cfg      (cfg_bus.sink),
        .capture  (capture),
        .is_wfi   (is_wfi)
    );

    packet_builder u_builder (
        .clk     (clk),
        .rst_n   (rst_n),
        .instr   (instr),
        .pc      (pc),
        .events  (events),
        .capture (capture),
        .packet  (packet)
    );

    // capture strobe doubles as the fifo push
    trace_stream_fifo u_fifo (
        .clk            (clk),
        .rst_n          (rst_n),
        .push           (capture),
        .packet         (packet),
        .is_wfi         (is_wfi),
        .tlast_interval (tlast_interval),
        .M_AXIS_tvalid  (M_AXIS_tvalid),
        .M_AXIS_tready  (M_AXIS_tready),
        .M_AXIS_tdata   (M_AXIS_tdata),
        .M_AXIS_tlast   (M_AXIS_tlast)
    );

endmodule

`default_nettype wire

// ==== tb/tb_trace_monitor.sv ====
// self-checking testbench for the trace monitor
// a reference model mirrors config, window, wfi count and counters per edge
// and queues the expected packets
// a compare process checks every stream beat against that queue
`timescale 1ns/1ps
`default_nettype none

module tb_trace_monitor import trace_pkg::*, monitor_ctrl_pkg::*; ();

    // the tests take about 800 cycles
    localparam int timeout_cycles = 4000;
    localparam instr_t nop_instr = 32'h0000_0013;

    logic        clk = 1'b0;
    logic        rst_n;
    instr_t      instr;
    pc_t         pc;
    logic        pc_valid;
    logic        en;
    evt_vec_t    events;
    ctrl_addr_t  ctrl_addr;
    ctrl_data_t  ctrl_wdata;
    logic        ctrl_write_enable;
    logic [31:0] tlast_interval;
    logic        M_AXIS_tvalid;
    logic        M_AXIS_tready;
    packet_t     M_AXIS_tdata;
    logic        M_AXIS_tlast;

    // model state
    logic        m_we_prev;
    logic        m_start_en;
    logic        m_end_en;
    logic        m_lower_en;
    logic        m_upper_en;
    pc_t         m_start_addr;
    pc_t         m_end_addr;
    pc_t         m_lower;
    pc_t         m_upper;
    window_t     m_win;
    logic [1:0]  m_wfi_cnt;
    stamp_t      m_cycle;
    stamp_t      m_last;
    evt_count_t  m_cnt [num_events];
    logic [31:0] m_push_cnt;
    int          m_level;

    packet_t     exp_pkt_q [$];
    logic        exp_last_q [$];
    int          beats_seen = 0;
    int          cycles = 0;
    logic [31:0] rng = 32'd13;

    trace_monitor_top dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // capture rule on the state from before the edge
    function automatic logic ref_capture(input pc_t p, input logic v, input logic e);
        logic win_ok;
        logic range_ok;
        win_ok = (!m_start_en || (m_win == win_started)) && (!m_end_en || (m_win != win_ended));
        range_ok = (!m_lower_en || (p >= m_lower)) && (!m_upper_en || (p <= m_upper));
        return e && v && (m_wfi_cnt < 2'd2) && win_ok && range_ok;
    endfunction

    always @(posedge clk) begin : reference_model
        logic   cap;
        logic   wfi;
        logic   acc;
        logic   tl;
        logic   push_ok;
        logic   pop;
        stamp_t delta;
        if (!rst_n) begin
            m_we_prev = 1'b0;
            m_start_en = 1'b0;
            m_end_en = 1'b0;
            m_lower_en = 1'b0;
            m_upper_en = 1'b0;
            m_start_addr = '0;
            m_end_addr = '1;
            m_lower = '0;
            m_upper = '1;
            m_win = win_idle;
            m_wfi_cnt = 2'd0;
            m_cycle = '0;
            m_last = '0;
            m_push_cnt = '0;
            m_level = 0;
            for (int i = 0; i < num_events; i++) begin
                m_cnt[i] = '0;
            end
        end else begin
            acc = ctrl_write_enable && !m_we_prev;
            wfi = (instr == wfi_instr);
            cap = ref_capture(pc, pc_valid, en);
            // a full fifo drops the capture even when a beat leaves
            push_ok = cap && (m_level != fifo_depth);
            pop = (m_level != 0) && M_AXIS_tready;
            if (push_ok) begin
                tl = wfi || ((tlast_interval != 32'd0) && (m_push_cnt + 32'd1 == tlast_interval));
                delta = m_cycle - m_last;
                exp_pkt_q.push_back({instr, delta, pc, m_cnt[0], m_cnt[1], m_cnt[2], m_cnt[3]});
                exp_last_q.push_back(tl);
                m_push_cnt = tl ? 32'd0 : m_push_cnt + 32'd1;
            end
            m_level = m_level + (push_ok ? 1 : 0) - (pop ? 1 : 0);
            // capture cycle clears and is not counted
            for (int i = 0; i < num_events; i++) begin
                if (cap) begin
                    m_cnt[i] = '0;
                end else if (events[i] && (m_cnt[i] != 8'hFF)) begin
                    m_cnt[i] = m_cnt[i] + 8'd1;
                end
            end
            if (cap) begin
                m_last = m_cycle;
            end
            m_cycle = m_cycle + 16'd1;
            // trigger hits judged on the old config and window
            if (!acc) begin
                if (m_end_en && (pc == m_end_addr)) begin
                    m_win = win_ended;
                end else if (m_start_en && (pc == m_start_addr)) begin
                    m_win = win_started;
                end
            end
            if (wfi && en && (m_wfi_cnt < 2'd2)) begin
                m_wfi_cnt = m_wfi_cnt + 2'd1;
            end else if (!wfi) begin
                m_wfi_cnt = 2'd0;
            end
            if (acc) begin
                case (ctrl_addr)
                    start_en:    m_start_en = ctrl_wdata[0];
                    end_en:      m_end_en = ctrl_wdata[0];
                    start_addr:  m_start_addr = ctrl_wdata;
                    end_addr:    m_end_addr = ctrl_wdata;
                    lower_en:    m_lower_en = ctrl_wdata[0];
                    upper_en:    m_upper_en = ctrl_wdata[0];
                    lower_bound: m_lower = ctrl_wdata;
                    upper_bound: m_upper = ctrl_wdata;
                    default:     ;
                endcase
            end
            m_we_prev = ctrl_write_enable;
        end
    end

    task automatic check_packet(input packet_t got, input packet_t exp);
        if (got !== exp) begin
            $display("Fail M_AXIS_tdata got %h expected %h", got, exp);
            $display("test failed");
            $fatal(1, "packet mismatch");
        end
    endtask

    task automatic check_tlast(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail M_AXIS_tlast got %h expected %h", got, exp);
            $display("test failed");
            $fatal(1, "tlast mismatch");
        end
    endtask

    // one expected entry per beat in order
    always @(posedge clk) begin : compare_beats
        if (rst_n && M_AXIS_tvalid && M_AXIS_tready) begin
            if (beats_seen >= exp_pkt_q.size()) begin
                $display("a packet left the stream port with no capture outstanding");
                $display("test failed");
                $fatal(1, "unexpected beat");
            end else begin
                check_packet(M_AXIS_tdata, exp_pkt_q[beats_seen]);
                check_tlast(M_AXIS_tlast, exp_last_q[beats_seen]);
                beats_seen = beats_seen + 1;
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("test failed");
            $fatal(1, "run did not finish within %0d cycles", timeout_cycles);
        end
    end

    task automatic drive_cycle(input instr_t i, input pc_t p, input logic v);
        @(posedge clk);
        rng = lcg(rng);
        instr <= i;
        pc <= p;
        pc_valid <= v;
        events <= rng[27:24];
    endtask

    // random non-wfi instruction word
    task automatic drive_random(input pc_t p, input logic v);
        instr_t i;
        rng = lcg(rng);
        i = (rng == wfi_instr) ? (rng ^ 32'd1) : rng;
        drive_cycle(i, p, v);
    endtask

    // strobe stays high two cycles and writes once on its rising edge
    task automatic write_reg(input ctrl_addr_t a, input ctrl_data_t d);
        @(posedge clk);
        ctrl_addr <= a;
        ctrl_wdata <= d;
        ctrl_write_enable <= 1'b1;
        repeat (2) @(posedge clk);
        ctrl_write_enable <= 1'b0;
    endtask

    // idle cycles until every queued packet has left the stream port
    task automatic drain();
        drive_cycle(nop_instr, pc_t'(0), 1'b0);
        @(negedge clk);
        while (beats_seen != exp_pkt_q.size()) begin
            drive_cycle(nop_instr, pc_t'(0), 1'b0);
            @(negedge clk);
        end
    endtask

    task automatic check_capture_count(input int base, input int n, input string what);
        @(negedge clk);
        if (exp_pkt_q.size() - base != n) begin
            $display("%s gave %0d captures instead of %0d", what, exp_pkt_q.size() - base, n);
            $display("test failed");
            $fatal(1, "capture count");
        end
    endtask

    initial begin : stimulus
        int base;
        int k;
        rst_n <= 1'b0;
        instr <= nop_instr;
        pc <= '0;
        pc_valid <= 1'b0;
        en <= 1'b0;
        events <= '0;
        ctrl_addr <= start_en;
        ctrl_wdata <= '0;
        ctrl_write_enable <= 1'b0;
        tlast_interval <= '0;
        M_AXIS_tready <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        en <= 1'b1;
        M_AXIS_tready <= 1'b1;

        // free capture with nothing enabled
        repeat (300) begin
            rng = lcg(rng);
            drive_random(rng, rng[29]);
        end
        drive_cycle(nop_instr, pc_t'(0), 1'b0);

        // address range 0x1000 to 0x1fff and then upper bound off
        write_reg(lower_bound, 32'h0000_1000);
        write_reg(upper_bound, 32'h0000_1FFF);
        write_reg(lower_en, 32'd1);
        write_reg(upper_en, 32'd1);
        repeat (60) begin
            rng = lcg(rng);
            drive_random(32'h0000_0800 + (rng & 32'h0000_1FFC), 1'b1);
        end
        drive_cycle(nop_instr, 32'h0000_3000, 1'b0);
        write_reg(upper_en, 32'd0);
        repeat (40) begin
            rng = lcg(rng);
            drive_random(32'h0000_0800 + (rng & 32'h0000_1FFC), 1'b1);
        end
        drive_cycle(nop_instr, 32'h0000_3000, 1'b0);

        // trigger window 0x4000 .. 0x4100
        write_reg(start_addr, 32'h0000_4000);
        write_reg(end_addr, 32'h0000_4100);
        write_reg(start_en, 32'd1);
        write_reg(end_en, 32'd1);
        base = exp_pkt_q.size();
        // start pc in the write cycle must not open the window
        @(posedge clk);
        pc <= 32'h0000_4000;
        pc_valid <= 1'b1;
        ctrl_addr <= start_addr;
        ctrl_wdata <= 32'h0000_4000;
        ctrl_write_enable <= 1'b1;
        @(posedge clk);
        pc <= 32'h0000_3000;
        ctrl_write_enable <= 1'b0;
        repeat (5) drive_random(32'h0000_3000, 1'b1);
        check_capture_count(base, 0, "closed trigger window");
        for (int a = 32'h3F80; a <= 32'h4180; a += 4) begin
            drive_random(pc_t'(a), 1'b1);
        end
        drive_cycle(nop_instr, 32'h0000_3000, 1'b0);
        write_reg(start_en, 32'd0);
        write_reg(end_en, 32'd0);

        // wfi run stops after two packets
        base = exp_pkt_q.size();
        // wfi pushes also restart the interval count
        tlast_interval <= 32'd3;
        for (int n = 0; n < 6; n++) begin
            drive_cycle(wfi_instr, 32'h0000_1500 + 32'(n * 4), 1'b1);
        end
        drive_cycle(nop_instr, 32'h0000_1600, 1'b0);
        check_capture_count(base, 2, "wfi run");
        repeat (4) drive_random(32'h0000_1604, 1'b1);
        drain();

        // interval tlast under back-pressure
        repeat (10) begin
            drive_cycle(nop_instr, 32'h0000_1000, 1'b0);
            M_AXIS_tready <= 1'b0;
            rng = lcg(rng);
            k = 1 + (int'(rng[18:16]) % 7);
            repeat (k) begin
                rng = lcg(rng);
                drive_random(32'h0000_1000 + (rng & 32'h0000_0FFC), 1'b1);
            end
            drive_cycle(nop_instr, 32'h0000_1000, 1'b0);
            M_AXIS_tready <= 1'b1;
            drain();
        end

        repeat (4) drive_cycle(nop_instr, pc_t'(0), 1'b0);
        @(negedge clk);
        if (M_AXIS_tvalid || (beats_seen != exp_pkt_q.size()) || (beats_seen == 0)) begin
            $display("stream not drained at the end, %0d of %0d packets seen",
                     beats_seen, exp_pkt_q.size());
            $display("test failed");
            $fatal(1, "end of run");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
design/trace_pkg.sv
design/monitor_ctrl_pkg.sv
design/trace_cfg_if.sv
design/monitor_regs.sv
design/capture_gate.sv
design/packet_builder.sv
design/trace_stream_fifo.sv
design/trace_monitor_top.sv
tb/tb_trace_monitor.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the trace monitor testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_trace_monitor -o sim_trace_monitor
status=$?
if [ "$status" -ne 0 ]; then
    echo "compile step failed with status $status"
    exit "$status"
fi

./obj_dir/sim_trace_monitor
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
